// ==== common/llc_defines.svh ====
`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

// number of ways, kept even so ways pair up in one RAM
`define LLC_WAYS 4

`define LLC_WAY_BITS $clog2(`LLC_WAYS)

// set index and derived set count
`define LLC_SET_BITS 6

`define LLC_SETS (1 << `LLC_SET_BITS)

// high set bits that pick a RAM bank
`define LLC_BANK_BITS 1

`define LLC_BANKS (1 << `LLC_BANK_BITS)

`define LLC_TAG_BITS 16

`define LLC_LINE_BITS 128

// one bit per sharing cache
`define LLC_SHARERS 16

`endif

// ==== common/llc_mem_pkg.sv ====
`include "llc_defines.svh"

package llc_mem_pkg;

    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;

    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;

    typedef logic [`LLC_LINE_BITS-1:0] line_t;

    typedef logic [`LLC_SHARERS-1:0] sharers_t;

    typedef logic [3:0] owner_t;

    // data or instruction access
    typedef logic hprot_t;

    // invalid must stay zero, the sweep writes an all-zero entry
    typedef enum logic [2:0] {
        LLC_INVALID   = 3'd0,
        LLC_VALID     = 3'd1,
        LLC_SHARED    = 3'd2,
        LLC_EXCLUSIVE = 3'd3,
        LLC_MODIFIED  = 3'd4
    } llc_state_t;

    // one stored entry per set and way
    typedef struct packed {
        line_t      line;
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        owner_t     owner;
        sharers_t   sharers;
        hprot_t     hprot;
    } llc_entry_t;

endpackage

// ==== common/llc_req_pkg.sv ====
package llc_req_pkg;

    import llc_mem_pkg::*;

    typedef enum logic {
        LLC_OP_LOOKUP = 1'b0,
        LLC_OP_FILL   = 1'b1
    } llc_op_t;

    // request toward the lookup unit
    // entry only matters for a fill, its tag field is not used
    typedef struct packed {
        llc_op_t    op;
        llc_set_t   set;
        llc_tag_t   tag;
        llc_entry_t entry;
    } llc_req_t;

    // lookup: hit entry, or on a miss the evict way's entry
    // fill: previous contents of the way that was written
    typedef struct packed {
        logic       hit;
        llc_way_t   way;
        llc_entry_t entry;
    } llc_rsp_t;

endpackage

// ==== localmem/bram_2p.sv ====
module bram_2p #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 512
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] a0,
    input  logic [WIDTH-1:0]         d0,
    input  logic                     we0,
    input  logic                     ce0,
    output logic [WIDTH-1:0]         q0,
    input  logic [$clog2(DEPTH)-1:0] a1,
    input  logic [WIDTH-1:0]         d1,
    input  logic                     we1,
    input  logic                     ce1,
    output logic [WIDTH-1:0]         q1
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read-first, q only moves on a chip-enabled read
    always_ff @(posedge clk) begin
        if (we0) begin
            mem[a0] <= d0;
        end
        if (we1) begin
            mem[a1] <= d1;
        end
        if (ce0) begin
            q0 <= mem[a0];
        end
        if (ce1) begin
            q1 <= mem[a1];
        end
    end

    a_no_write_collision: assert property (@(posedge clk) !(we0 && we1 && (a0 == a1)))
        else $error("bram_2p: both ports write address %0d", a0);

endmodule

// ==== localmem/llc_localmem.sv ====
`include "llc_defines.svh"

module llc_localmem import llc_mem_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rd_en,
    input  llc_set_t                      rd_set,
    output llc_entry_t [`LLC_WAYS-1:0]    rd_entries,
    output llc_way_t                      rd_evict_way,
    input  logic                          wr_en,
    input  llc_set_t                      wr_set,
    input  llc_way_t                      wr_way,
    input  llc_entry_t                    wr_entry,
    input  llc_way_t                      wr_evict_way
);

    localparam int PAIRS = `LLC_WAYS / 2;
    localparam int BANKS = `LLC_BANKS;
    localparam int ROW_BITS = `LLC_SET_BITS - `LLC_BANK_BITS;
    localparam int ENTRY_BITS = $bits(llc_entry_t);
    localparam int WAY_BITS = $bits(llc_way_t);

    logic [ROW_BITS-1:0] row;
    logic [`LLC_BANK_BITS-1:0] rd_bank;
    logic [`LLC_BANK_BITS-1:0] wr_bank;
    logic [`LLC_BANK_BITS-1:0] bank_q;

    logic [BANKS-1:0] ce_bank;
    logic [BANKS-1:0] wr_bank_hit;
    logic [BANKS-1:0][PAIRS-1:0] we_even;
    logic [BANKS-1:0][PAIRS-1:0] we_odd;

    llc_entry_t q_even [BANKS][PAIRS];
    llc_entry_t q_odd [BANKS][PAIRS];
    llc_way_t q_evict [BANKS];

    // one address path, the write set wins
    assign row = wr_en ? wr_set[ROW_BITS-1:0] : rd_set[ROW_BITS-1:0];
    assign rd_bank = rd_set[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];
    assign wr_bank = wr_set[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];

    // bank and way-pair decode, parity picks the port
    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            ce_bank[b] = rd_en && (rd_bank == b);
            wr_bank_hit[b] = wr_en && (wr_bank == b);
            for (int p = 0; p < PAIRS; p++) begin
                we_even[b][p] = wr_bank_hit[b] && ((wr_way >> 1) == p) && !wr_way[0];
                we_odd[b][p] = wr_bank_hit[b] && ((wr_way >> 1) == p) && wr_way[0];
            end
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        for (genvar p = 0; p < PAIRS; p++) begin : g_pair
            // lower half holds way 2p, upper half way 2p+1
            bram_2p #(
                .WIDTH(ENTRY_BITS),
                .DEPTH(2 << ROW_BITS)
            ) entry_ram (
                .clk(clk),
                .a0({1'b0, row}),
                .d0(wr_entry),
                .we0(we_even[b][p]),
                .ce0(ce_bank[b]),
                .q0(q_even[b][p]),
                .a1({1'b1, row}),
                .d1(wr_entry),
                .we1(we_odd[b][p]),
                .ce1(ce_bank[b]),
                .q1(q_odd[b][p])
            );
        end

        // evict pointer, port 1 idle
        bram_2p #(
            .WIDTH(WAY_BITS),
            .DEPTH(1 << ROW_BITS)
        ) evict_ram (
            .clk(clk),
            .a0(row),
            .d0(wr_evict_way),
            .we0(wr_bank_hit[b]),
            .ce0(ce_bank[b]),
            .q0(q_evict[b]),
            .a1('0),
            .d1('0),
            .we1(1'b0),
            .ce1(1'b0),
            .q1()
        );
    end

    // remember which bank answers in the data cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_q <= '0;
        end else if (rd_en) begin
            bank_q <= rd_bank;
        end
    end

    always_comb begin
        for (int p = 0; p < PAIRS; p++) begin
            rd_entries[2*p] = q_even[bank_q][p];
            rd_entries[2*p+1] = q_odd[bank_q][p];
        end
        rd_evict_way = q_evict[bank_q];
    end

    // the shared address path cannot serve both
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && wr_en))
        else $error("llc_localmem: read and write in the same cycle");

endmodule

// ==== verilog/llc_lookup.sv ====
`include "llc_defines.svh"

module llc_lookup import llc_mem_pkg::*, llc_req_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  llc_req_t                      req,
    input  logic                          req_valid,
    output logic                          req_ready,
    output llc_rsp_t                      rsp,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output logic                          rd_en,
    output llc_set_t                      rd_set,
    input  llc_entry_t [`LLC_WAYS-1:0]    rd_entries,
    input  llc_way_t                      rd_evict_way,
    output logic                          wr_en,
    output llc_set_t                      wr_set,
    output llc_way_t                      wr_way,
    output llc_entry_t                    wr_entry,
    output llc_way_t                      wr_evict_way
);

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_READ,
        ST_COMPARE,
        ST_RESPOND
    } lookup_state_t;

    lookup_state_t state;
    lookup_state_t state_next;

    llc_req_t req_q;
    llc_set_t sweep_set;
    llc_way_t sweep_way;
    logic sweep_last;

    logic [`LLC_WAYS-1:0] hit_vec;
    logic hit;
    llc_way_t hit_way;
    llc_way_t sel_way;
    llc_way_t evict_next;
    llc_entry_t fill_entry;

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESPOND);
    assign rd_en = (state == ST_READ);
    assign rd_set = req_q.set;

    assign sweep_last = (sweep_set == llc_set_t'(`LLC_SETS - 1)) &&
                        (sweep_way == llc_way_t'(`LLC_WAYS - 1));

    // tag compare on the data returned for the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            hit_vec[w] = (rd_entries[w].state != LLC_INVALID) &&
                         (rd_entries[w].tag == req_q.tag);
            if (hit_vec[w]) begin
                hit_way = llc_way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;
    assign sel_way = hit ? hit_way : rd_evict_way;

    // round robin pointer that moves only on a miss
    assign evict_next = (rd_evict_way == llc_way_t'(`LLC_WAYS - 1)) ? '0 : rd_evict_way + 1'b1;

    always_comb begin
        fill_entry = req_q.entry;
        fill_entry.tag = req_q.tag;
    end

    always_comb begin
        if (state == ST_SWEEP) begin
            // sweep writes start once reset is released
            wr_en = rst_n;
            wr_set = sweep_set;
            wr_way = sweep_way;
            wr_entry = '0;
            wr_entry.state = LLC_INVALID;
            wr_evict_way = '0;
        end else begin
            wr_en = (state == ST_COMPARE) && (req_q.op == LLC_OP_FILL);
            wr_set = req_q.set;
            wr_way = sel_way;
            wr_entry = fill_entry;
            wr_evict_way = hit ? rd_evict_way : evict_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_SWEEP: begin
                if (sweep_last) begin
                    state_next = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (req_valid) begin
                    state_next = ST_READ;
                end
            end
            ST_READ: state_next = ST_COMPARE;
            ST_COMPARE: state_next = ST_RESPOND;
            ST_RESPOND: begin
                if (rsp_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_SWEEP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_SWEEP;
            sweep_set <= '0;
            sweep_way <= '0;
        end else begin
            state <= state_next;
            if (state == ST_SWEEP) begin
                if (sweep_way == llc_way_t'(`LLC_WAYS - 1)) begin
                    sweep_way <= '0;
                    sweep_set <= sweep_set + 1'b1;
                end else begin
                    sweep_way <= sweep_way + 1'b1;
                end
            end
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state == ST_COMPARE) begin
            rsp.hit <= hit;
            rsp.way <= sel_way;
            rsp.entry <= rd_entries[sel_way];
        end
    end

    // fills only ever place a tag once per set
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_COMPARE) |-> $onehot0(hit_vec))
        else $error("llc_lookup: more than one way hit in set %0d", req_q.set);

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("llc_lookup: response changed while held");

endmodule

// ==== verilog/llc_top.sv ====
`include "llc_defines.svh"

module llc_top import llc_mem_pkg::*, llc_req_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  llc_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output llc_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready
);

    logic rd_en;
    llc_set_t rd_set;
    llc_entry_t [`LLC_WAYS-1:0] rd_entries;
    llc_way_t rd_evict_way;
    logic wr_en;
    llc_set_t wr_set;
    llc_way_t wr_way;
    llc_entry_t wr_entry;
    llc_way_t wr_evict_way;

    llc_lookup lookup_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .rsp(rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rd_en(rd_en),
        .rd_set(rd_set),
        .rd_entries(rd_entries),
        .rd_evict_way(rd_evict_way),
        .wr_en(wr_en),
        .wr_set(wr_set),
        .wr_way(wr_way),
        .wr_entry(wr_entry),
        .wr_evict_way(wr_evict_way)
    );

    llc_localmem localmem_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rd_en(rd_en),
        .rd_set(rd_set),
        .rd_entries(rd_entries),
        .rd_evict_way(rd_evict_way),
        .wr_en(wr_en),
        .wr_set(wr_set),
        .wr_way(wr_way),
        .wr_entry(wr_entry),
        .wr_evict_way(wr_evict_way)
    );

endmodule

// ==== verif/llc_tb.sv ====
`include "llc_defines.svh"

module llc_tb import llc_mem_pkg::*, llc_req_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 1000;
    localparam int SWEEP_CYCLES = `LLC_WAYS * `LLC_SETS;
    localparam int RSP_LATENCY = 2;

    logic clk = 1'b0;
    logic rst_n;
    llc_req_t req;
    logic req_valid;
    logic req_ready;
    llc_rsp_t rsp;
    logic rsp_valid;
    logic rsp_ready;

    int check_errors;
    int timeout_errors;
    logic [31:0] rng_state;

    // reference contents indexed by set
    llc_entry_t model_entry [`LLC_SETS][`LLC_WAYS];
    llc_way_t model_evict [`LLC_SETS];

    llc_top llc_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .rsp(rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready)
    );

    initial begin
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // state never invalid so a filled entry can hit
    function automatic llc_entry_t random_entry();
        llc_entry_t e;
        logic [31:0] rnd;
        e = '0;
        for (int i = 0; i < (`LLC_LINE_BITS + 31) / 32; i++) begin
            e.line = (e.line << 32) | line_t'(next_random());
        end
        rnd = next_random();
        e.tag = llc_tag_t'(rnd >> 16);
        e.state = llc_state_t'(3'(1 + (rnd % 4)));
        e.dirty = rnd[4];
        e.owner = rnd[11:8];
        e.hprot = rnd[12];
        e.sharers = sharers_t'(next_random());
        return e;
    endfunction

    function automatic llc_req_t make_req(input llc_op_t op, input llc_set_t set_idx,
                                          input llc_tag_t tag, input llc_entry_t entry);
        llc_req_t r;
        r.op = op;
        r.set = set_idx;
        r.tag = tag;
        r.entry = entry;
        return r;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < `LLC_SETS; s++) begin
            model_evict[s] = '0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                model_entry[s][w] = '0;
            end
        end
    endtask

    // expected response followed by the effect of a fill on the set
    task automatic model_step(input llc_req_t r, output llc_rsp_t exp);
        logic hit;
        llc_way_t way;
        llc_entry_t stored;
        hit = 1'b0;
        way = model_evict[r.set];
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (model_entry[r.set][w].state != LLC_INVALID &&
                model_entry[r.set][w].tag == r.tag) begin
                hit = 1'b1;
                way = llc_way_t'(w);
            end
        end
        exp.hit = hit;
        exp.way = way;
        exp.entry = model_entry[r.set][way];
        if (r.op == LLC_OP_FILL) begin
            stored = r.entry;
            stored.tag = r.tag;
            model_entry[r.set][way] = stored;
            if (!hit) begin
                model_evict[r.set] = llc_way_t'((int'(way) + 1) % `LLC_WAYS);
            end
        end
    endtask

    task automatic check_rsp(input string name, input llc_rsp_t got, input llc_rsp_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_entry(input string name, input llc_entry_t got,
                               input llc_entry_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_way(input string name, input llc_way_t got, input llc_way_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            check_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic wait_sweep();
        int cycles;
        cycles = 0;
        while (!req_ready && cycles < SWEEP_CYCLES + TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) begin
            timeout_errors++;
            $display("time %0t: reset sweep never finished, req_ready stayed low", $time);
        end else begin
            check_count("sweep_cycles", cycles, SWEEP_CYCLES);
        end
    endtask

    task automatic send_request(input llc_req_t r);
        int cycles;
        if (timeout_errors != 0) begin
            return;
        end
        @(negedge clk);
        req = r;
        req_valid = 1'b1;
        cycles = 0;
        while (!req_ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) begin
            timeout_errors++;
            $display("time %0t: request was never accepted, req_ready stayed low", $time);
        end
        // taken on the rising edge just passed
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_response(output llc_rsp_t got, output int cycles);
        got = '0;
        cycles = 0;
        if (timeout_errors != 0) begin
            return;
        end
        while (!rsp_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!rsp_valid) begin
            timeout_errors++;
            $display("time %0t: no response arrived, rsp_valid stayed low", $time);
        end
        got = rsp;
    endtask

    task automatic issue(input llc_req_t r, output llc_rsp_t got);
        llc_rsp_t exp;
        int cycles;
        model_step(r, exp);
        send_request(r);
        wait_response(got, cycles);
        if (timeout_errors == 0) begin
            check_count("rsp_latency", cycles, RSP_LATENCY);
            check_rsp("rsp", got, exp);
        end
    endtask

    task automatic test_sweep_misses();
        llc_rsp_t got;
        for (int i = 0; i < 8; i++) begin
            issue(make_req(LLC_OP_LOOKUP, llc_set_t'(next_random()),
                           llc_tag_t'(next_random()), '0), got);
            check_flag("rsp.hit", got.hit, 1'b0);
            check_way("rsp.way", got.way, '0);
            check_flag("rsp.entry.state==invalid", got.entry.state == LLC_INVALID, 1'b1);
        end
    endtask

    task automatic test_fill_empty();
        llc_rsp_t got;
        llc_tag_t tag;
        llc_entry_t e;
        llc_entry_t stored;
        tag = llc_tag_t'(next_random());
        e = random_entry();
        issue(make_req(LLC_OP_FILL, llc_set_t'(5), tag, e), got);
        check_flag("fill rsp.hit", got.hit, 1'b0);
        check_way("fill rsp.way", got.way, '0);
        check_flag("victim state==invalid", got.entry.state == LLC_INVALID, 1'b1);
        stored = e;
        stored.tag = tag;
        issue(make_req(LLC_OP_LOOKUP, llc_set_t'(5), tag, '0), got);
        check_flag("lookup rsp.hit", got.hit, 1'b1);
        check_way("lookup rsp.way", got.way, '0);
        check_entry("lookup rsp.entry", got.entry, stored);
    endtask

    task automatic test_evict_order();
        llc_rsp_t got;
        llc_tag_t base;
        llc_entry_t fills [`LLC_WAYS];
        llc_entry_t first;
        base = llc_tag_t'(next_random());
        for (int i = 0; i < `LLC_WAYS; i++) begin
            fills[i] = random_entry();
            issue(make_req(LLC_OP_FILL, llc_set_t'(37), base + llc_tag_t'(i), fills[i]), got);
            check_flag("fill rsp.hit", got.hit, 1'b0);
            check_way("fill rsp.way", got.way, llc_way_t'(i));
        end
        first = fills[0];
        first.tag = base;
        // wraps back to way 0 and evicts the first fill
        issue(make_req(LLC_OP_FILL, llc_set_t'(37), base + llc_tag_t'(`LLC_WAYS),
                       random_entry()), got);
        check_way("wrap rsp.way", got.way, '0);
        check_entry("victim entry", got.entry, first);
    endtask

    task automatic test_fill_hit();
        llc_rsp_t got;
        llc_tag_t base;
        llc_entry_t e0;
        llc_entry_t e_new;
        llc_entry_t stored;
        base = llc_tag_t'(next_random());
        e0 = random_entry();
        issue(make_req(LLC_OP_FILL, llc_set_t'(50), base, e0), got);
        issue(make_req(LLC_OP_FILL, llc_set_t'(50), base + 1'b1, random_entry()), got);
        e_new = random_entry();
        stored = e0;
        stored.tag = base;
        issue(make_req(LLC_OP_FILL, llc_set_t'(50), base, e_new), got);
        check_flag("refill rsp.hit", got.hit, 1'b1);
        check_way("refill rsp.way", got.way, '0);
        check_entry("refill old entry", got.entry, stored);
        stored = e_new;
        stored.tag = base;
        issue(make_req(LLC_OP_LOOKUP, llc_set_t'(50), base, '0), got);
        check_entry("rewritten entry", got.entry, stored);
        // evict pointer still at way 2
        issue(make_req(LLC_OP_FILL, llc_set_t'(50), base + 2'd2, random_entry()), got);
        check_flag("miss rsp.hit", got.hit, 1'b0);
        check_way("miss rsp.way", got.way, llc_way_t'(2));
    endtask

    task automatic test_random_mix();
        llc_rsp_t got;
        llc_tag_t base;
        llc_set_t lo_set;
        llc_set_t hi_set;
        logic [31:0] rnd;
        llc_op_t op;
        base = llc_tag_t'(next_random());
        // same row and same tags in both banks over all ways
        lo_set = llc_set_t'(9);
        hi_set = lo_set ^ llc_set_t'(1 << (`LLC_SET_BITS - 1));
        for (int i = 0; i < `LLC_WAYS; i++) begin
            issue(make_req(LLC_OP_FILL, lo_set, base + llc_tag_t'(i), random_entry()), got);
            issue(make_req(LLC_OP_FILL, hi_set, base + llc_tag_t'(i), random_entry()), got);
        end
        for (int i = 0; i < `LLC_WAYS; i++) begin
            issue(make_req(LLC_OP_LOOKUP, lo_set, base + llc_tag_t'(i), '0), got);
            issue(make_req(LLC_OP_LOOKUP, hi_set, base + llc_tag_t'(i), '0), got);
        end
        // small tag pool keeps the hit rate up
        for (int i = 0; i < 150; i++) begin
            rnd = next_random();
            op = rnd[0] ? LLC_OP_FILL : LLC_OP_LOOKUP;
            issue(make_req(op, llc_set_t'(rnd >> 8),
                           base + llc_tag_t'(rnd[18:16] % 6), random_entry()), got);
        end
    endtask

    task automatic test_backpressure();
        llc_req_t r;
        llc_rsp_t exp;
        llc_rsp_t held;
        int cycles;
        r = make_req(LLC_OP_LOOKUP, llc_set_t'(9), llc_tag_t'(next_random()), '0);
        model_step(r, exp);
        // let the previous response finish first
        @(negedge clk);
        rsp_ready = 1'b0;
        send_request(r);
        wait_response(held, cycles);
        if (timeout_errors == 0) begin
            check_count("rsp_latency", cycles, RSP_LATENCY);
            check_rsp("held rsp", held, exp);
            for (int i = 0; i < 6; i++) begin
                @(negedge clk);
                check_flag("rsp_valid held", rsp_valid, 1'b1);
                check_flag("req_ready held", req_ready, 1'b0);
                check_rsp("rsp held", rsp, exp);
            end
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        if (timeout_errors == 0) begin
            check_flag("rsp_valid after take", rsp_valid, 1'b0);
            check_flag("req_ready after take", req_ready, 1'b1);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        check_errors = 0;
        timeout_errors = 0;
        rng_state = 32'h51866203;
        model_reset();
        repeat (5) @(negedge clk);
        check_flag("rsp_valid in reset", rsp_valid, 1'b0);
        check_flag("req_ready in reset", req_ready, 1'b0);
        rst_n = 1'b1;
        wait_sweep();
        test_sweep_misses();
        test_fill_empty();
        test_evict_order();
        test_fill_hit();
        test_random_mix();
        test_backpressure();
        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/llc_mem_pkg.sv
common/llc_req_pkg.sv
localmem/bram_2p.sv
localmem/llc_localmem.sv
verilog/llc_lookup.sv
verilog/llc_top.sv
verif/llc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= llc_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
